// ==== vlog.f ====
rtl/wasm_pkg.sv
rtl/stack_if.sv
rtl/code_rom.sv
rtl/leb128_decoder.sv
rtl/operand_stack.sv
rtl/value_alu.sv
rtl/wasm_control.sv
rtl/wasm_core.sv
tb/wasm_core_asserts.sv
tb/wasm_core_tb.sv

// ==== tb/wasm_core_input.txt ====
# b addr data: code byte / p type value: operand push, type 0 i32 1 i64 2 f32 3 f64
# s addr: start address / e trap empty type value: expected outcome, runs the test
b 00 41
b 01 7e
b 02 42
b 03 ac
b 04 02
b 05 0b
e 1 0 1 000000000000012c
b 00 41
b 01 7e
b 02 42
b 03 ac
b 04 02
b 05 1a
b 06 0b
e 1 0 0 00000000fffffffe
p 0 5
p 0 5
b 00 46
b 01 0b
e 1 0 0 1
p 1 7
p 1 8
b 00 52
b 01 0b
e 1 0 0 1
p 0 0
b 00 45
b 01 0b
e 1 0 0 1
p 1 100000000
b 00 50
b 01 0b
e 1 0 0 0
p 1 1111
p 1 2222
p 0 0
b 00 1b
b 01 0b
e 1 0 1 1111
p 0 7
p 0 9
p 0 3
b 00 1b
b 01 0b
e 1 0 0 9
p 2 3f800000
b 00 bc
b 01 0b
e 1 0 0 3f800000
p 1 4000000000000000
b 00 bf
b 01 0b
e 1 0 3 4000000000000000
p 1 1
p 1 2
b 00 6a
e 3 0 1 2
p 0 1
p 1 2
p 0 1
b 00 1b
e 4 0 0 1
b 00 1a
e 5 1 0 0
b 00 00
e 2 1 0 0
b 00 ff
e 7 1 0 0
b 40 42
b 41 7f
b 42 01
b 43 0b
s 40
e 1 0 1 ffffffffffffffff

// ==== tb/wasm_core_tb.sv ====
`timescale 1ns/1ps

module wasm_core_tb import wasm_pkg::*; ();

  localparam int ROM_ADDR    = 8;
  localparam int STACK_DEPTH = 4;
  localparam int TRIALS      = 200;

  logic                clk;
  logic                reset;
  logic [ROM_ADDR-1:0] pc;
  logic                prog_we;
  logic [ROM_ADDR-1:0] prog_addr;
  logic [7:0]          prog_data;
  logic                push;
  stack_entry_t        push_entry;
  logic [63:0]         result;
  value_type_e         result_type;
  logic                result_empty;
  trap_e               trap;

  // Records as read from the stimulus file
  logic [7:0]  kind_q [$];
  logic [63:0] f0_q [$];
  logic [63:0] f1_q [$];
  logic [63:0] f2_q [$];
  logic [63:0] f3_q [$];

  // The test being assembled
  logic [ROM_ADDR-1:0] code_addr_q [$];
  logic [7:0]          code_data_q [$];
  stack_entry_t        push_q [$];
  logic [ROM_ADDR-1:0] start_addr;

  int error_count = 0;
  int test_count  = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  wasm_core #(.ROM_ADDR(ROM_ADDR), .STACK_DEPTH(STACK_DEPTH)) u_dut (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .push         (push),
    .push_entry   (push_entry),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .trap         (trap)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: no trap after %0d cycles, errors so far %0d", cycle_limit, error_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic show_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("error at %0t: test %0d %s = %0h, expected %0h", $time, test_count, name, got, exp);
    error_count++;
  endtask

  task automatic load_records();
    int          fd;
    int          code;
    logic        done;
    logic [7:0]  kind;
    string       line;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    done = 1'b0;
    fd   = $fopen("tb/wasm_core_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/wasm_core_input.txt");
      error_count++;
    end else begin
      while (!done) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          code = $fgets(line, fd);
          // Lines starting with # are notes
          if (kind != "#") begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            code = $sscanf(line, "%h %h %h %h", a, b, c, d);
            kind_q.push_back(kind);
            f0_q.push_back(a);
            f1_q.push_back(b);
            f2_q.push_back(c);
            f3_q.push_back(d);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input trap_e exp_trap, input logic exp_empty,
                          input value_type_e exp_type, input logic [63:0] exp_value);
    int n;
    int i;
    n = (code_addr_q.size() > 8) ? code_addr_q.size() : 8;
    test_count++;
    reset = 1'b1;
    pc    = start_addr;
    // Code bytes go in while the core sits in reset
    for (i = 0; i < n; i++) begin
      prog_we = i < code_addr_q.size();
      if (prog_we) begin
        prog_addr = code_addr_q[i];
        prog_data = code_data_q[i];
      end
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    reset   = 1'b0;
    // Pushes hold the sequence, so operands land before the first opcode
    for (i = 0; i < push_q.size(); i++) begin
      push       = 1'b1;
      push_entry = push_q[i];
      @(posedge clk);
      #1;
    end
    push = 1'b0;
    while (trap === NONE) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    if (trap !== exp_trap) show_error("trap", 64'(trap), 64'(exp_trap));
    if (result_empty !== exp_empty) show_error("result_empty", 64'(result_empty), 64'(exp_empty));
    if (!exp_empty && result_type !== exp_type) begin
      show_error("result_type", 64'(result_type), 64'(exp_type));
    end
    if (!exp_empty && result !== exp_value) show_error("result", result, exp_value);
    code_addr_q.delete();
    code_data_q.delete();
    push_q.delete();
    start_addr = '0;
  endtask

  // Two operands, one add or sub, then end
  task automatic random_trial();
    logic         wide;
    logic         is_sub;
    logic [63:0]  a;
    logic [63:0]  b;
    logic [63:0]  expected;
    logic [7:0]   opc;
    stack_entry_t entry;
    wide   = $urandom % 2;
    is_sub = $urandom % 2;
    a      = {$urandom, $urandom};
    b      = {$urandom, $urandom};
    if (!wide) begin
      a[63:32] = 32'h0;
      b[63:32] = 32'h0;
    end
    if (wide) begin
      opc = is_sub ? 8'h7d : 8'h7c;
    end else begin
      opc = is_sub ? 8'h6b : 8'h6a;
    end
    // Second operand minus top, wrapping at the operand width
    expected = is_sub ? a - b : a + b;
    if (!wide) expected[63:32] = 32'h0;
    code_addr_q.push_back(8'h00);
    code_data_q.push_back(opc);
    code_addr_q.push_back(8'h01);
    code_data_q.push_back(8'h0b);
    entry.vtype = wide ? i64 : i32;
    entry.value = a;
    push_q.push_back(entry);
    entry.value = b;
    push_q.push_back(entry);
    run_test(ENDED, 1'b0, entry.vtype, expected);
  endtask

  // One push more than the stack holds
  task automatic overflow_test();
    stack_entry_t entry;
    int           i;
    code_addr_q.push_back(8'h00);
    code_data_q.push_back(8'h0b);
    for (i = 0; i <= 2 ** STACK_DEPTH; i++) begin
      entry.vtype = i32;
      entry.value = 64'(i);
      push_q.push_back(entry);
    end
    run_test(STACK_ERROR, 1'b0, i32, 64'(2 ** STACK_DEPTH - 1));
  endtask

  initial begin
    int i;
    reset      = 1'b1;
    pc         = '0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    push       = 1'b0;
    push_entry = '0;
    start_addr = '0;
    void'($urandom(32'hb7dd));
    load_records();
    cycle_limit = kind_q.size() * 40 + TRIALS * 200;
    @(posedge clk);
    #1;
    for (i = 0; i < kind_q.size(); i++) begin
      case (kind_q[i])
        "b": begin
          code_addr_q.push_back(f0_q[i][ROM_ADDR-1:0]);
          code_data_q.push_back(f1_q[i][7:0]);
        end
        "p": push_q.push_back('{vtype: value_type_e'(f0_q[i][1:0]), value: f1_q[i]});
        "s": start_addr = f0_q[i][ROM_ADDR-1:0];
        "e": run_test(trap_e'(f0_q[i][3:0]), f1_q[i][0], value_type_e'(f2_q[i][1:0]), f3_q[i]);
        default: begin
          $display("unknown record kind %c in the stimulus file", kind_q[i]);
          error_count++;
        end
      endcase
    end
    for (i = 0; i < TRIALS; i++) begin
      random_trial();
    end
    overflow_test();
    $display("tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/wasm_core_asserts.sv ====
`timescale 1ns/1ps

module wasm_core_asserts import wasm_pkg::*; (
  input logic      clk,
  input logic      reset,
  input trap_e     trap,
  input step_e     step,
  input stack_op_e op
);

  // A raised trap sticks until the next reset
  trap_holds: assert property (@(posedge clk) disable iff (reset)
    (trap != NONE) |=> (reset || $stable(trap)))
    else $error("trap changed while the core was not in reset");

  // Nothing reaches the stack right after reset
  op_idle_after_reset: assert property (@(posedge clk) reset |=> (op == IDLE))
    else $error("stack op not IDLE in the cycle after reset");

  step_legal: assert property (@(posedge clk) disable iff (reset)
    step inside {FETCH, FETCH2, EXEC})
    else $error("control step left its legal states");

endmodule

bind wasm_control wasm_core_asserts u_asserts (
  .clk   (clk),
  .reset (reset),
  .trap  (trap),
  .step  (step),
  .op    (st.op)
);

// ==== rtl/wasm_core.sv ====
`timescale 1ns/1ps

module wasm_core import wasm_pkg::*; #(
  parameter int ROM_ADDR    = 8,
  parameter int STACK_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [ROM_ADDR-1:0] pc,
  input  logic                prog_we,
  input  logic [ROM_ADDR-1:0] prog_addr,
  input  logic [7:0]          prog_data,
  input  logic                push,
  input  stack_entry_t        push_entry,
  output logic [63:0]         result,
  output value_type_e         result_type,
  output logic                result_empty,
  output trap_e               trap
);

  logic [WINDOW_BYTES-1:0][7:0] window;
  logic [ROM_ADDR-1:0]          fetch_addr;
  logic [63:0]                  imm_value;
  logic [3:0]                   imm_len;
  opcode_e                      opcode;
  stack_entry_t                 alu_result;

  stack_if #(.STACK_DEPTH(STACK_DEPTH)) st_bus ();

  code_rom #(.ROM_ADDR(ROM_ADDR)) u_rom (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .addr      (fetch_addr),
    .window    (window)
  );

  // Immediate follows the opcode byte
  leb128_decoder u_leb (
    .bytes (window[WINDOW_BYTES-1:1]),
    .value (imm_value),
    .len   (imm_len)
  );

  wasm_control #(.ROM_ADDR(ROM_ADDR), .STACK_DEPTH(STACK_DEPTH)) u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .push       (push),
    .push_entry (push_entry),
    .window     (window),
    .fetch_addr (fetch_addr),
    .imm_value  (imm_value),
    .imm_len    (imm_len),
    .alu_result (alu_result),
    .opcode     (opcode),
    .st         (st_bus.control),
    .trap       (trap)
  );

  value_alu u_alu (
    .opcode (opcode),
    .tos    (st_bus.tos),
    .nos    (st_bus.nos),
    .third  (st_bus.third),
    .result (alu_result)
  );

  operand_stack #(.STACK_DEPTH(STACK_DEPTH)) u_stack (
    .clk   (clk),
    .reset (reset),
    .st    (st_bus.stack)
  );

  assign result       = st_bus.tos.value;
  assign result_type  = st_bus.tos.vtype;
  assign result_empty = st_bus.count == '0;

endmodule

// ==== rtl/wasm_control.sv ====
`timescale 1ns/1ps

module wasm_control import wasm_pkg::*; #(
  parameter int ROM_ADDR    = 8,
  parameter int STACK_DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [ROM_ADDR-1:0]          pc,
  input  logic                         push,
  input  stack_entry_t                 push_entry,
  input  logic [WINDOW_BYTES-1:0][7:0] window,
  output logic [ROM_ADDR-1:0]          fetch_addr,
  input  logic [63:0]                  imm_value,
  input  logic [3:0]                   imm_len,
  input  stack_entry_t                 alu_result,
  output opcode_e                      opcode,
  stack_if.control                     st,
  output trap_e                        trap
);

  localparam int CAPACITY = 2 ** STACK_DEPTH;

  step_e                step;
  logic [ROM_ADDR-1:0]  prog_counter;
  logic [STACK_DEPTH:0] count_next;
  logic                 full;
  logic                 known;
  logic [1:0]           need;
  logic                 check_tos;
  logic                 check_nos;
  value_type_e          want;
  stack_op_e            exec_op;
  stack_entry_t         const_entry;
  logic                 type_error;

  assign opcode = opcode_e'(window[0]);

  // Count after the op issued last cycle has landed
  assign count_next = st.count + (STACK_DEPTH + 1)'(count_delta(st.op));
  assign full       = count_next == (STACK_DEPTH + 1)'(CAPACITY);

  // Operand needs and stack op per opcode
  always_comb begin
    known     = 1'b1;
    need      = 2'd0;
    check_tos = 1'b0;
    check_nos = 1'b0;
    want      = i32;
    exec_op   = IDLE;
    case (opcode)
      op_unreachable, op_nop, op_end: begin
      end
      op_drop: begin
        need    = 2'd1;
        exec_op = POP;
      end
      op_select: begin
        need      = 2'd3;
        check_tos = 1'b1;
        exec_op   = COLLAPSE3;
      end
      op_i32_const, op_i64_const: exec_op = PUSH;
      op_i32_eqz, op_i64_eqz, op_i32_reinterpret_f32, op_i64_reinterpret_f64,
      op_f32_reinterpret_i32, op_f64_reinterpret_i64: begin
        need      = 2'd1;
        check_tos = 1'b1;
        exec_op   = REPLACE;
        case (opcode)
          op_i64_eqz, op_f64_reinterpret_i64: want = i64;
          op_i32_reinterpret_f32:             want = f32;
          op_i64_reinterpret_f64:             want = f64;
          default:                            want = i32;
        endcase
      end
      op_i32_eq, op_i32_ne, op_i32_add, op_i32_sub,
      op_i64_eq, op_i64_ne, op_i64_add, op_i64_sub: begin
        need      = 2'd2;
        check_tos = 1'b1;
        check_nos = 1'b1;
        exec_op   = COLLAPSE2;
        want      = opcode inside {op_i64_eq, op_i64_ne, op_i64_add, op_i64_sub} ? i64 : i32;
      end
      default: known = 1'b0;
    endcase
  end

  assign const_entry.vtype = (opcode == op_i64_const) ? i64 : i32;
  assign const_entry.value = (opcode == op_i64_const) ? imm_value : {32'h0, imm_value[31:0]};

  assign type_error = (check_tos && st.tos.vtype != want) ||
                      (check_nos && st.nos.vtype != want);

  always_ff @(posedge clk) begin
    if (reset) begin
      step         <= FETCH;
      prog_counter <= pc;
      trap         <= NONE;
      st.op        <= IDLE;
    end else begin
      st.op <= IDLE;
      // External push wins and freezes the sequence
      if (push) begin
        if (!full) begin
          st.op   <= PUSH;
          st.data <= push_entry;
        end else if (trap == NONE) begin
          trap <= STACK_ERROR;
        end
      end else if (trap == NONE) begin
        case (step)
          FETCH: begin
            fetch_addr <= prog_counter;
            step       <= FETCH2;
          end
          FETCH2: step <= EXEC;
          EXEC: begin
            // Wait for a push from the previous cycle to land
            if (st.op == IDLE) begin
              step         <= FETCH;
              prog_counter <= prog_counter + ROM_ADDR'(1);
              if (!known) begin
                trap <= UNKNOWN_OPCODE;
              end else if (opcode == op_unreachable) begin
                trap <= UNREACHABLE;
              end else if (opcode == op_end) begin
                trap <= ENDED;
              end else if (st.count < (STACK_DEPTH + 1)'(need)) begin
                trap <= STACK_EMPTY;
              end else if (exec_op == PUSH && full) begin
                trap <= STACK_ERROR;
              end else if (type_error) begin
                trap <= TYPE_MISMATCH;
              end else if (opcode == op_select && st.nos.vtype != st.third.vtype) begin
                trap <= TYPES_MISMATCH;
              end else begin
                st.op   <= exec_op;
                st.data <= (exec_op == PUSH) ? const_entry : alu_result;
                if (exec_op == PUSH) begin
                  prog_counter <= prog_counter + ROM_ADDR'(imm_len) + ROM_ADDR'(1);
                end
              end
            end
          end
          default: step <= FETCH;
        endcase
      end
    end
  end

endmodule

// ==== rtl/value_alu.sv ====
`timescale 1ns/1ps

module value_alu import wasm_pkg::*; (
  input  opcode_e      opcode,
  input  stack_entry_t tos,
  input  stack_entry_t nos,
  input  stack_entry_t third,
  output stack_entry_t result
);

  logic [31:0] sum32;
  logic [31:0] diff32;
  logic [63:0] sum64;
  logic [63:0] diff64;

  // Comparisons always produce an i32
  function automatic stack_entry_t flag(input logic b);
    flag = '{vtype: i32, value: {63'h0, b}};
  endfunction

  // Second operand minus top of stack
  assign sum32  = nos.value[31:0] + tos.value[31:0];
  assign diff32 = nos.value[31:0] - tos.value[31:0];
  assign sum64  = nos.value + tos.value;
  assign diff64 = nos.value - tos.value;

  always_comb begin
    result = tos;
    case (opcode)
      op_i32_eqz: result = flag(tos.value[31:0] == 32'h0);
      op_i64_eqz: result = flag(tos.value == 64'h0);
      op_i32_eq:  result = flag(nos.value[31:0] == tos.value[31:0]);
      op_i32_ne:  result = flag(nos.value[31:0] != tos.value[31:0]);
      op_i64_eq:  result = flag(nos.value == tos.value);
      op_i64_ne:  result = flag(nos.value != tos.value);
      op_i32_add: result = '{vtype: i32, value: {32'h0, sum32}};
      op_i32_sub: result = '{vtype: i32, value: {32'h0, diff32}};
      op_i64_add: result = '{vtype: i64, value: sum64};
      op_i64_sub: result = '{vtype: i64, value: diff64};
      op_select:  result = (tos.value[31:0] != 32'h0) ? nos : third;
      // Bits stay, only the type changes
      op_i32_reinterpret_f32: result.vtype = i32;
      op_i64_reinterpret_f64: result.vtype = i64;
      op_f32_reinterpret_i32: result.vtype = f32;
      op_f64_reinterpret_i64: result.vtype = f64;
      default: begin
      end
    endcase
  end

endmodule

// ==== rtl/operand_stack.sv ====
`timescale 1ns/1ps

module operand_stack import wasm_pkg::*; #(
  parameter int STACK_DEPTH = 4
) (
  input logic    clk,
  input logic    reset,
  stack_if.stack st
);

  localparam int SLOTS = 2 ** STACK_DEPTH;

  stack_entry_t           mem [SLOTS];
  logic [STACK_DEPTH-1:0] push_idx;
  logic [STACK_DEPTH-1:0] top_idx;
  logic [STACK_DEPTH-1:0] nos_idx;
  logic [STACK_DEPTH-1:0] third_idx;

  // Slot indices wrap, so a full stack still addresses its top
  assign push_idx  = st.count[STACK_DEPTH-1:0];
  assign top_idx   = push_idx - STACK_DEPTH'(1);
  assign nos_idx   = push_idx - STACK_DEPTH'(2);
  assign third_idx = push_idx - STACK_DEPTH'(3);

  assign st.tos   = mem[top_idx];
  assign st.nos   = mem[nos_idx];
  assign st.third = mem[third_idx];

  // Result of a collapse lands in the lowest consumed slot
  always_ff @(posedge clk) begin
    case (st.op)
      PUSH:      mem[push_idx] <= st.data;
      REPLACE:   mem[top_idx] <= st.data;
      COLLAPSE2: mem[nos_idx] <= st.data;
      COLLAPSE3: mem[third_idx] <= st.data;
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      st.count <= '0;
    end else begin
      st.count <= st.count + (STACK_DEPTH + 1)'(count_delta(st.op));
    end
  end

endmodule

// ==== rtl/leb128_decoder.sv ====
`timescale 1ns/1ps

module leb128_decoder (
  input  logic [9:0][7:0] bytes,
  output logic [63:0]     value,
  output logic [3:0]      len
);

  // Ten groups of seven bits overrun 64 bits
  logic [69:0] acc;
  logic        done;

  always_comb begin
    acc  = '0;
    len  = 4'd10;
    done = 1'b0;
    for (int i = 0; i < 10; i++) begin
      if (!done) begin
        acc[7*i +: 7] = bytes[i][6:0];
        if (!bytes[i][7]) begin
          done = 1'b1;
          len  = 4'(i + 1);
          // Sign bit of the last group fills everything above it
          if (bytes[i][6]) begin
            acc = acc | ({70{1'b1}} << (7 * (i + 1)));
          end
        end
      end
    end
  end

  assign value = acc[63:0];

endmodule

// ==== rtl/code_rom.sv ====
`timescale 1ns/1ps

module code_rom import wasm_pkg::*; #(
  parameter int ROM_ADDR = 8
) (
  input  logic                         clk,
  input  logic                         prog_we,
  input  logic [ROM_ADDR-1:0]          prog_addr,
  input  logic [7:0]                   prog_data,
  input  logic [ROM_ADDR-1:0]          addr,
  output logic [WINDOW_BYTES-1:0][7:0] window
);

  localparam int BYTES = 2 ** ROM_ADDR;

  logic [7:0]                   mem [BYTES];
  logic [WINDOW_BYTES-1:0][7:0] next_window;

  // Extra address bit flags reads past the last byte
  for (genvar i = 0; i < WINDOW_BYTES; i++) begin : g_window
    logic [ROM_ADDR:0] idx;

    assign idx = {1'b0, addr} + (ROM_ADDR + 1)'(i);
    assign next_window[i] = idx[ROM_ADDR] ? 8'h00 : mem[idx[ROM_ADDR-1:0]];
  end

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
    window <= next_window;
  end

endmodule

// ==== rtl/stack_if.sv ====
`timescale 1ns/1ps

interface stack_if import wasm_pkg::*; #(
  parameter int STACK_DEPTH = 4
);

  stack_op_e            op;
  stack_entry_t         data;
  logic [STACK_DEPTH:0] count;

  // Three entries at the top, tos first
  stack_entry_t tos;
  stack_entry_t nos;
  stack_entry_t third;

  modport control (output op, data, input count, tos, nos, third);
  modport stack (input op, data, output count, tos, nos, third);

endinterface

// ==== rtl/wasm_pkg.sv ====
package wasm_pkg;

  // Operand types as they sit in a stack slot
  typedef enum logic [1:0] {
    i32 = 2'd0,
    i64 = 2'd1,
    f32 = 2'd2,
    f64 = 2'd3
  } value_type_e;

  // 32-bit types keep the upper half of value at zero
  typedef struct packed {
    value_type_e vtype;
    logic [63:0] value;
  } stack_entry_t;

  typedef enum logic [7:0] {
    op_unreachable         = 8'h00,
    op_nop                 = 8'h01,
    op_end                 = 8'h0B,
    op_drop                = 8'h1A,
    op_select              = 8'h1B,
    op_i32_const           = 8'h41,
    op_i64_const           = 8'h42,
    op_i32_eqz             = 8'h45,
    op_i32_eq              = 8'h46,
    op_i32_ne              = 8'h47,
    op_i64_eqz             = 8'h50,
    op_i64_eq              = 8'h51,
    op_i64_ne              = 8'h52,
    op_i32_add             = 8'h6A,
    op_i32_sub             = 8'h6B,
    op_i64_add             = 8'h7C,
    op_i64_sub             = 8'h7D,
    op_i32_reinterpret_f32 = 8'hBC,
    op_i64_reinterpret_f64 = 8'hBD,
    op_f32_reinterpret_i32 = 8'hBE,
    op_f64_reinterpret_i64 = 8'hBF
  } opcode_e;

  typedef enum logic [3:0] {
    NONE,
    ENDED,
    UNREACHABLE,
    TYPE_MISMATCH,
    TYPES_MISMATCH,
    STACK_EMPTY,
    STACK_ERROR,
    UNKNOWN_OPCODE
  } trap_e;

  typedef enum logic [2:0] {IDLE, PUSH, POP, REPLACE, COLLAPSE2, COLLAPSE3} stack_op_e;

  typedef enum logic [1:0] {FETCH, FETCH2, EXEC} step_e;

  // Opcode byte plus the longest LEB128 immediate
  localparam int WINDOW_BYTES = 11;

  // Change of the entry count caused by one stack op
  function automatic int count_delta(input stack_op_e op);
    case (op)
      PUSH:           return 1;
      POP, COLLAPSE2: return -1;
      COLLAPSE3:      return -2;
      default:        return 0;
    endcase
  endfunction

endpackage
